//--- include/sched_params.svh
// Sizing macros for the issue scheduler: ROB depth, search window and sequence-number width
`ifndef SCHED_PARAMS_SVH
`define SCHED_PARAMS_SVH

// ============================================================
// Reorder buffer geometry
// ============================================================

// Number of ROB entries, kept a power of two so an index wraps cleanly
`define SCHED_ROB_ENTRIES 8

// Entries examined each cycle, counted from the head
// Must not exceed the ROB depth
`define SCHED_WINDOW_SIZE 6

// ============================================================
// Ordering
// ============================================================

// Sequence-number width, a smaller number is an older instruction
`define SCHED_SN_BITS 8

`endif

//--- verilog/sched_pkg.sv
// Scheduler types: ROB index, entry bitmask, instruction kind, ROB entry, ROB array, unit issue
`include "sched_params.svh"

package sched_pkg;

	// ============================================================
	// Indexing
	// ============================================================

	// Index of one ROB entry
	typedef logic [$clog2(`SCHED_ROB_ENTRIES)-1:0] rob_ndx_t;

	// One bit per ROB entry, bit n belongs to entry n
	typedef logic [`SCHED_ROB_ENTRIES-1:0] rob_bitmask_t;

	// ============================================================
	// ROB entry
	// ============================================================

	// KIND_ALU and KIND_SYNC both run on an ALU
	// KIND_FC runs on the flow-control unit
	// KIND_OTHER belongs to some other unit and never issues from here
	typedef enum logic [1:0] {
		KIND_ALU   = 2'd0,
		KIND_SYNC  = 2'd1,
		KIND_FC    = 2'd2,
		KIND_OTHER = 2'd3
	} sched_kind_t;

	// Scheduling view of a ROB entry, 17 bits
	// done[0] flags execution complete, done[1] flags flow control complete
	// args_v[0] is operand A valid and args_v[1] is operand B valid
	typedef struct packed {
		logic                      v;
		logic [`SCHED_SN_BITS-1:0] sn;
		logic [1:0]                done;
		logic [1:0]                args_v;
		sched_kind_t               kind;
		logic                      alu_pair;
		logic                      alu0_only;
	} rob_entry_t;

	// Whole ROB, element n is entry n
	typedef rob_entry_t [`SCHED_ROB_ENTRIES-1:0] rob_t;

	// ============================================================
	// Issue record
	// ============================================================

	// What one functional unit receives, a valid flag and the chosen entry
	typedef struct packed {
		logic     v;
		rob_ndx_t rndx;
	} unit_issue_t;

endpackage

//--- verilog/sched_alu_ready.sv
// ALU readiness evaluator: per-entry ALU eligibility with blocking behind older sync instructions
`timescale 1ns/100ps
`include "sched_params.svh"

module sched_alu_ready (
	input  logic                    clk,
	input  logic                    rst,
	input  sched_pkg::rob_t         rob_i,
	input  sched_pkg::rob_bitmask_t alu_issue_i,
	output sched_pkg::rob_bitmask_t alu_ok_o
);

	import sched_pkg::*;

	// Entry has a valid sync instruction ahead of it in program order
	rob_bitmask_t prior_sync;
	// Eligibility before the register
	rob_bitmask_t next_ok;

	// ============================================================
	// Older sync search
	// ============================================================

	// Every entry is compared against every other entry by sequence number
	// The cost grows with the square of the ROB depth, which is small here
	always_comb begin
		prior_sync = '0;
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			for (int j = 0; j < `SCHED_ROB_ENTRIES; j++) begin
				// An entry never counts as older than itself since sn is equal
				if (rob_i[j].v && rob_i[j].kind == KIND_SYNC && rob_i[j].sn < rob_i[i].sn)
					prior_sync[i] = 1'b1;
			end
		end
	end

	// ============================================================
	// Eligibility
	// ============================================================

	always_comb begin
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			// A sync instruction itself runs on an ALU and so qualifies here
			// Entries younger than it wait until it leaves the ROB
			next_ok[i] = rob_i[i].v
				&& (rob_i[i].kind == KIND_ALU || rob_i[i].kind == KIND_SYNC)
				&& !rob_i[i].done[0]
				&& (&rob_i[i].args_v)
				&& !prior_sync[i]
				// Issued last cycle, so it must not be picked a second time
				&& !alu_issue_i[i];
		end
	end

	// One cycle of latency from the sampled ROB to the mask
	always_ff @(posedge clk) begin
		if (rst)
			alu_ok_o <= '0;
		else
			alu_ok_o <= next_ok;
	end

endmodule

//--- verilog/sched_fc_order.sv
// Flow-control ordering evaluator: per-entry FCU eligibility that keeps flow control in program order
`timescale 1ns/100ps
`include "sched_params.svh"

module sched_fc_order (
	input  logic                    clk,
	input  logic                    rst,
	input  sched_pkg::rob_t         rob_i,
	input  sched_pkg::rob_bitmask_t fc_issue_i,
	output sched_pkg::rob_bitmask_t fc_ok_o
);

	import sched_pkg::*;

	// An older flow-control op has not finished yet
	rob_bitmask_t prior_fc;
	// An older sync instruction is still in the ROB
	rob_bitmask_t prior_sync;
	rob_bitmask_t next_ok;

	// ============================================================
	// Older entry searches
	// ============================================================

	always_comb begin
		prior_fc   = '0;
		prior_sync = '0;
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			for (int j = 0; j < `SCHED_ROB_ENTRIES; j++) begin
				if (rob_i[j].v && rob_i[j].sn < rob_i[i].sn) begin
					// A finished branch no longer holds back the ones behind it
					if (rob_i[j].kind == KIND_FC && !rob_i[j].done[1])
						prior_fc[i] = 1'b1;
					if (rob_i[j].kind == KIND_SYNC)
						prior_sync[i] = 1'b1;
				end
			end
		end
	end

	// ============================================================
	// Eligibility
	// ============================================================

	// With the prior_fc term at most one flow-control entry qualifies at a time
	always_comb begin
		for (int i = 0; i < `SCHED_ROB_ENTRIES; i++) begin
			next_ok[i] = rob_i[i].v
				&& rob_i[i].kind == KIND_FC
				&& !rob_i[i].done[1]
				&& (&rob_i[i].args_v)
				&& !prior_fc[i]
				&& !prior_sync[i]
				&& !fc_issue_i[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			fc_ok_o <= '0;
		else
			fc_ok_o <= next_ok;
	end

endmodule

//--- verilog/sched_select.sv
// Window selector: walks the ROB from the head and assigns ALU0, ALU1 and the FCU
`timescale 1ns/100ps
`include "sched_params.svh"

module sched_select (
	input  logic                    clk,
	input  logic                    rst,
	input  sched_pkg::rob_t         rob_i,
	input  sched_pkg::rob_ndx_t     head_i,
	input  sched_pkg::rob_bitmask_t alu_ok_i,
	input  sched_pkg::rob_bitmask_t fc_ok_i,
	input  logic                    alu0_idle_i,
	input  logic                    alu1_idle_i,
	input  logic                    fcu_idle_i,
	output sched_pkg::unit_issue_t  alu0_o,
	output sched_pkg::unit_issue_t  alu1_o,
	output sched_pkg::unit_issue_t  fcu_o,
	output sched_pkg::rob_bitmask_t alu_issue_o,
	output sched_pkg::rob_bitmask_t fc_issue_o
);

	import sched_pkg::*;

	// Window entries in age order, heads[0] is the head itself
	rob_ndx_t [`SCHED_WINDOW_SIZE-1:0] heads;
	// Entry being visited by the walk
	rob_ndx_t ndx;

	// A unit has already been claimed earlier in the walk
	logic alu0_taken;
	logic alu1_taken;
	// The oldest flow-control candidate has been seen
	logic fc_seen;

	unit_issue_t  next_alu0;
	unit_issue_t  next_alu1;
	unit_issue_t  next_fcu;
	rob_bitmask_t next_alu_issue;
	rob_bitmask_t next_fc_issue;

	// Index wraps at the end of the ROB back to entry 0
	always_comb begin
		for (int k = 0; k < `SCHED_WINDOW_SIZE; k++)
			heads[k] = rob_ndx_t'((int'(head_i) + k) % `SCHED_ROB_ENTRIES);
	end

	// ============================================================
	// Window walk
	// ============================================================

	// Older entries get first pick because the walk starts at the head
	always_comb begin
		ndx            = '0;
		alu0_taken     = 1'b0;
		alu1_taken     = 1'b0;
		fc_seen        = 1'b0;
		next_alu0      = '0;
		next_alu1      = '0;
		next_fcu       = '0;
		next_alu_issue = '0;
		next_fc_issue  = '0;
		for (int k = 0; k < `SCHED_WINDOW_SIZE; k++) begin
			ndx = heads[k];
			if (alu_ok_i[ndx]) begin
				// A pair op needs both ALUs in the same cycle
				if (rob_i[ndx].alu_pair && !alu0_taken && !alu1_taken
						&& alu0_idle_i && alu1_idle_i) begin
					alu0_taken          = 1'b1;
					alu1_taken          = 1'b1;
					next_alu0           = '{v: 1'b1, rndx: ndx};
					next_alu1           = '{v: 1'b1, rndx: ndx};
					next_alu_issue[ndx] = 1'b1;
				end
				else if (!alu0_taken && alu0_idle_i) begin
					alu0_taken          = 1'b1;
					next_alu0           = '{v: 1'b1, rndx: ndx};
					next_alu_issue[ndx] = 1'b1;
				end
				// ALU1 lacks some functions, so ALU0-only ops wait for a later cycle
				else if (!rob_i[ndx].alu0_only && !alu1_taken && alu1_idle_i) begin
					alu1_taken          = 1'b1;
					next_alu1           = '{v: 1'b1, rndx: ndx};
					next_alu_issue[ndx] = 1'b1;
				end
			end
			// Only the oldest candidate may go, even if the FCU is busy
			if (fc_ok_i[ndx] && !fc_seen) begin
				fc_seen = 1'b1;
				if (fcu_idle_i) begin
					next_fcu           = '{v: 1'b1, rndx: ndx};
					next_fc_issue[ndx] = 1'b1;
				end
			end
		end
	end

	// ============================================================
	// Result registers
	// ============================================================

	// The issue masks also feed back to the evaluators
	always_ff @(posedge clk) begin
		if (rst) begin
			alu0_o      <= '0;
			alu1_o      <= '0;
			fcu_o       <= '0;
			alu_issue_o <= '0;
			fc_issue_o  <= '0;
		end
		else begin
			alu0_o      <= next_alu0;
			alu1_o      <= next_alu1;
			fcu_o       <= next_fcu;
			alu_issue_o <= next_alu_issue;
			fc_issue_o  <= next_fc_issue;
		end
	end

endmodule

//--- verilog/sched_top.sv
// Scheduler top level: ALU readiness and flow-control ordering evaluators feeding the window selector
`timescale 1ns/100ps

module sched_top (
	input  logic                    clk,
	input  logic                    rst,
	input  sched_pkg::rob_t         rob_i,
	input  sched_pkg::rob_ndx_t     head_i,
	input  logic                    alu0_idle_i,
	input  logic                    alu1_idle_i,
	input  logic                    fcu_idle_i,
	output sched_pkg::unit_issue_t  alu0_o,
	output sched_pkg::unit_issue_t  alu1_o,
	output sched_pkg::unit_issue_t  fcu_o,
	output sched_pkg::rob_bitmask_t alu_issue_o,
	output sched_pkg::rob_bitmask_t fc_issue_o
);

	import sched_pkg::*;

	// Registered eligibility from the two evaluators
	rob_bitmask_t alu_ok;
	rob_bitmask_t fc_ok;

	// Both evaluators see the same ROB snapshot in the same cycle
	// The issue masks come back so a just-issued entry is not picked again
	sched_alu_ready u_alu_ready (
		.clk         (clk),
		.rst         (rst),
		.rob_i       (rob_i),
		.alu_issue_i (alu_issue_o),
		.alu_ok_o    (alu_ok)
	);

	sched_fc_order u_fc_order (
		.clk        (clk),
		.rst        (rst),
		.rob_i      (rob_i),
		.fc_issue_i (fc_issue_o),
		.fc_ok_o    (fc_ok)
	);

	// Selector resolves one cycle behind the evaluators
	sched_select u_select (
		.clk         (clk),
		.rst         (rst),
		.rob_i       (rob_i),
		.head_i      (head_i),
		.alu_ok_i    (alu_ok),
		.fc_ok_i     (fc_ok),
		.alu0_idle_i (alu0_idle_i),
		.alu1_idle_i (alu1_idle_i),
		.fcu_idle_i  (fcu_idle_i),
		.alu0_o      (alu0_o),
		.alu1_o      (alu1_o),
		.fcu_o       (fcu_o),
		.alu_issue_o (alu_issue_o),
		.fc_issue_o  (fc_issue_o)
	);

endmodule

//--- tests/sched_tb.sv
// Scheduler testbench: clock, reset, vector loading, stimulus, typed compare tasks and timeout
`timescale 1ns/100ps
`include "sched_params.svh"

module sched_tb;

	import sched_pkg::*;

	// ============================================================
	// Vector file layout
	// ============================================================

	// Words per line: head, idle, eight entries, then five expected values
	localparam int VEC_WORDS   = 15;
	localparam int NUM_VECTORS = 18;
	localparam string DATA_FILE = "tests/sched_tests.txt";
	// Four cycles per vector plus room for reset and the first bubble
	localparam int CYCLE_LIMIT = 4 * NUM_VECTORS + 20;

	logic clk;
	logic rst;
	rob_t         rob_i;
	rob_ndx_t     head_i;
	logic         alu0_idle_i;
	logic         alu1_idle_i;
	logic         fcu_idle_i;
	unit_issue_t  alu0_o;
	unit_issue_t  alu1_o;
	unit_issue_t  fcu_o;
	rob_bitmask_t alu_issue_o;
	rob_bitmask_t fc_issue_o;

	logic [$bits(rob_entry_t)-1:0] vec_mem [0:NUM_VECTORS*VEC_WORDS-1];
	integer seed;
	int cycle_count = 0;

	sched_top UUT (
		.clk         (clk),
		.rst         (rst),
		.rob_i       (rob_i),
		.head_i      (head_i),
		.alu0_idle_i (alu0_idle_i),
		.alu1_idle_i (alu1_idle_i),
		.fcu_idle_i  (fcu_idle_i),
		.alu0_o      (alu0_o),
		.alu1_o      (alu1_o),
		.fcu_o       (fcu_o),
		.alu_issue_o (alu_issue_o),
		.fc_issue_o  (fc_issue_o)
	);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Ends a run that stops making progress
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("TESTS FAILED");
			$fatal(1, "Timeout after %0d cycles, the vector sequence did not finish", cycle_count);
		end
	end

	// ============================================================
	// Compare tasks
	// ============================================================

	task automatic check_issue(input string name, input unit_issue_t exp, input unit_issue_t act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected v=%0b rndx=%0d, actual v=%0b rndx=%0d",
				$time, name, exp.v, exp.rndx, act.v, act.rndx);
			$display("TESTS FAILED");
			$fatal(1, "Wrong value on %s", name);
		end
	endtask

	task automatic check_mask(input string name, input rob_bitmask_t exp, input rob_bitmask_t act);
		if (act !== exp) begin
			$display("** Error at %0t: %s expected %b, actual %b", $time, name, exp, act);
			$display("TESTS FAILED");
			$fatal(1, "Wrong value on %s", name);
		end
	endtask

	// All outputs quiet, as during and right after reset
	task automatic check_outputs_clear();
		check_issue("alu0_o", '0, alu0_o);
		check_issue("alu1_o", '0, alu1_o);
		check_issue("fcu_o", '0, fcu_o);
		check_mask("alu_issue_o", '0, alu_issue_o);
		check_mask("fc_issue_o", '0, fc_issue_o);
	endtask

	task automatic check_vector(input int n);
		int base;
		base = n * VEC_WORDS;
		check_issue("alu0_o", vec_mem[base+10][3:0], alu0_o);
		check_issue("alu1_o", vec_mem[base+11][3:0], alu1_o);
		check_issue("fcu_o", vec_mem[base+12][3:0], fcu_o);
		check_mask("alu_issue_o", vec_mem[base+13][`SCHED_ROB_ENTRIES-1:0], alu_issue_o);
		check_mask("fc_issue_o", vec_mem[base+14][`SCHED_ROB_ENTRIES-1:0], fc_issue_o);
	endtask

	// ============================================================
	// Stimulus tasks
	// ============================================================

	task automatic load_vectors();
		int fd;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("TESTS FAILED");
			$fatal(1, "Cannot open the vector file %s", DATA_FILE);
		end
		else begin
			$fclose(fd);
			$readmemh(DATA_FILE, vec_mem);
		end
	endtask

	task automatic drive_vector(input int n);
		int base;
		base = n * VEC_WORDS;
		head_i      = vec_mem[base][2:0];
		// Idle column holds alu0, alu1 and fcu from the top bit down
		alu0_idle_i = vec_mem[base+1][2];
		alu1_idle_i = vec_mem[base+1][1];
		fcu_idle_i  = vec_mem[base+1][0];
		for (int e = 0; e < `SCHED_ROB_ENTRIES; e++)
			rob_i[e] = vec_mem[base+2+e];
	endtask

	// Every entry invalid so both issue masks drain before the next vector
	// Operand bits are scrambled since an invalid entry must ignore them
	task automatic drive_bubble();
		logic [31:0] rnd;
		rob_entry_t  ent;
		head_i      = '0;
		alu0_idle_i = 1'b1;
		alu1_idle_i = 1'b1;
		fcu_idle_i  = 1'b1;
		for (int e = 0; e < `SCHED_ROB_ENTRIES; e++) begin
			rnd        = $random(seed);
			ent        = '0;
			ent.args_v = rnd[1:0];
			rob_i[e]   = ent;
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		seed        = 32'hd179;
		rst         = 1'b1;
		rob_i       = '0;
		head_i      = '0;
		alu0_idle_i = 1'b0;
		alu1_idle_i = 1'b0;
		fcu_idle_i  = 1'b0;
		load_vectors();
		// Ready entries sit on the inputs during reset, yet nothing may issue
		drive_vector(0);
		repeat (4) begin
			@(posedge clk);
			#1;
			check_outputs_clear();
		end
		rst = 1'b0;
		// Eligibility masks are still clear on the first edge out of reset
		@(posedge clk);
		#1;
		check_outputs_clear();
		drive_bubble();
		@(posedge clk);
		@(posedge clk);
		#1;
		for (int n = 0; n < NUM_VECTORS; n++) begin
			drive_vector(n);
			// First edge loads the evaluators, the second loads the selector
			@(posedge clk);
			@(posedge clk);
			#1;
			check_vector(n);
			drive_bubble();
			@(posedge clk);
			@(posedge clk);
			#1;
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- tests/sched_tests.txt
// Columns: head, idle {alu0 alu1 fcu}, ROB entries 0 to 7, then expected alu0 alu1 fcu alu_issue fc_issue
// Entry word {v, sn[7:0], done[1:0], args_v[1:0], kind[1:0], alu_pair, alu0_only}, issue word {v, rndx}
// Basic ALU issue, skipping a missing operand and a done entry, then a non-ALU kind
0 7 10130 10210 10370 10430 10530 00000 00000 00000 8 b 0 09 00
0 7 1013c 10230 00000 00000 00000 00000 00000 00000 9 0 0 02 00
// Pair takes both ALUs, ALU0-only entries and idle inputs
0 7 10132 10230 00000 00000 00000 00000 00000 00000 8 8 0 01 00
0 7 10130 10231 10330 00000 00000 00000 00000 00000 8 a 0 05 00
0 7 10131 10230 00000 00000 00000 00000 00000 00000 8 9 0 03 00
0 3 10130 10231 10330 00000 00000 00000 00000 00000 0 8 0 01 00
0 5 10130 10230 00000 00000 00000 00000 00000 00000 8 0 0 01 00
0 0 10130 10238 00000 00000 00000 00000 00000 00000 0 0 0 00 00
// Sync blocking of younger ALU and FC entries
0 7 10134 10230 10330 10438 00000 00000 00000 00000 8 0 0 01 00
0 7 10130 10214 10330 00000 00000 00000 00000 00000 8 0 0 01 00
// Flow control in order, and an FCU that is busy
0 7 10118 10238 10330 00000 00000 00000 00000 00000 a 0 0 04 00
0 7 101b8 10238 10338 00000 00000 00000 00000 00000 0 0 9 00 02
0 6 101b8 10238 10338 00000 00000 00000 00000 00000 0 0 0 00 00
0 7 10130 10238 10330 10430 00000 00000 00000 00000 8 a 9 05 02
// Window limit and wrap past the end of the ROB
0 7 10110 10210 10310 10410 10510 10610 10730 10838 0 0 0 00 00
6 7 10330 10438 00000 00000 00000 00000 10110 10230 f 8 9 81 02
4 7 10510 10630 10730 10838 10110 10210 10310 10410 9 0 0 02 00
7 7 10230 00000 00000 00000 00000 00000 00000 10132 f f 0 80 00

//--- sched_top.f
+incdir+include
verilog/sched_pkg.sv
verilog/sched_alu_ready.sv
verilog/sched_fc_order.sv
verilog/sched_select.sv
verilog/sched_top.sv
tests/sched_tb.sv

//--- Makefile
# Verilator build and run for the issue scheduler testbench

TOP := sched_tb

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -f sched_top.f --top-module $(TOP)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
